//--- all.f
source/llq_pkg.sv
source/llq_decode.sv
source/llq_free_pool.sv
source/llq_execute.sv
source/llq_result.sv
source/llq_top.sv
verif/llq_tb.sv

//--- source/llq_decode.sv
// Commands are refused until all NUM_CTXT contexts are cleared after rst; no other back-pressure
`default_nettype none

module llq_decode
  import llq_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // Command side
  input  logic              cmd_pass,
  input  logic              cmd_push,
  input  logic [DATA_W-1:0] cmd_data,
  input  logic [CTXT_W-1:0] cmd_ctxt,
  output logic              cmd_accept,
  output logic              busy_r,
  // Command register towards execute
  output logic              dec_valid,
  output cmd_op_e           dec_op,
  output logic [CTXT_W-1:0] dec_ctxt,
  output logic [DATA_W-1:0] dec_data,
  // Context clear writes
  output logic              init_wr,
  output logic [CTXT_W-1:0] init_ctxt
);

  init_state_e       state_q;     // Init FSM
  init_state_e       state_nxt;
  logic [CTXT_W-1:0] ctxt_q;      // Context being cleared
  logic [CTXT_W-1:0] ctxt_nxt;
  logic              take_cmd;

  // Step one context per cycle
  always_comb
  begin
    state_nxt = state_q;
    ctxt_nxt  = ctxt_q;
    case (state_q)
      INIT_RESET:
      begin
        state_nxt = INIT_CLEAR;  // Context zero cleared this cycle
        ctxt_nxt  = ctxt_q + CTXT_W'(1);
      end
      INIT_CLEAR:
      begin
        ctxt_nxt = ctxt_q + CTXT_W'(1);
        if (ctxt_q == CTXT_W'(NUM_CTXT - 1))
        begin
          state_nxt = INIT_DONE;  // Last context written
        end
      end
      default:
        state_nxt = state_q;  // Done, or an unused encoding
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= INIT_RESET;
      ctxt_q  <= '0;
    end
    else
    begin
      state_q <= state_nxt;
      ctxt_q  <= ctxt_nxt;
    end
  end

  // Clear writes in every state but done
  assign init_wr    = (state_q != INIT_DONE);
  assign init_ctxt  = ctxt_q;
  assign busy_r     = (state_q != INIT_DONE);  // Straight from the state flop
  assign cmd_accept = (state_q == INIT_DONE);

  assign take_cmd = cmd_pass & cmd_accept;

  // Valid bit of the command register
  always_ff @(posedge clk)
  begin
    if (rst)
      dec_valid <= 1'b0;
    else
      dec_valid <= take_cmd;  // High for the single cycle after the accept
  end

  // Payload only loads on an accepted command
  always_ff @(posedge clk)
  begin
    if (take_cmd)
    begin
      dec_op   <= cmd_push ? OP_PUSH : OP_POP;
      dec_ctxt <= cmd_ctxt;
      dec_data <= cmd_data;
    end
  end

endmodule

`default_nettype wire

//--- source/llq_execute.sv
// Tables are read combinationally for the decoded command and written at the next edge
`default_nettype none

module llq_execute
  import llq_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // Command register
  input  logic              dec_valid,
  input  cmd_op_e           dec_op,
  input  logic [CTXT_W-1:0] dec_ctxt,
  input  logic [DATA_W-1:0] dec_data,
  // Init clear
  input  logic              init_wr,
  input  logic [CTXT_W-1:0] init_ctxt,
  // Towards result
  output logic              ex_valid,
  output logic              ex_rnw,
  output logic              ex_fault,
  output logic              ex_empty,
  output logic [LINK_W-1:0] ex_addr,
  output logic [DATA_W-1:0] ex_data,
  output logic [CTXT_W-1:0] ex_ctxt,
  output logic              pool_full_next
);

  // Per-context state table
  logic              empty_q [NUM_CTXT];
  logic [LINK_W-1:0] head_q  [NUM_CTXT];  // Oldest link, next to pop
  logic [LINK_W-1:0] tail_q  [NUM_CTXT];  // Newest link
  // Shared link table, entry points to the next younger link
  logic [LINK_W-1:0] link_q  [NUM_LINK];

  logic              cur_empty;
  logic [LINK_W-1:0] cur_head;
  logic [LINK_W-1:0] cur_tail;
  logic              is_push;
  logic              do_push;
  logic              do_pop;
  logic              last_link;   // Pop drains the context
  logic [LINK_W-1:0] alloc_id;
  logic              any_free;

  // Lookup of the addressed context
  assign cur_empty = empty_q[dec_ctxt];
  assign cur_head  = head_q[dec_ctxt];
  assign cur_tail  = tail_q[dec_ctxt];
  assign last_link = (cur_head == cur_tail);

  assign is_push = (dec_op == OP_PUSH);

  // Fault on empty pop or a push into a full pool
  assign ex_fault = dec_valid & (is_push ? ~any_free : cur_empty);
  assign do_push  = dec_valid & is_push & ~ex_fault;
  assign do_pop   = dec_valid & ~is_push & ~ex_fault;

  // Result operands
  assign ex_valid = dec_valid;
  assign ex_rnw   = ~is_push;                         // Pop reads the data store
  assign ex_addr  = is_push ? alloc_id : cur_head;
  assign ex_data  = dec_data;
  assign ex_ctxt  = dec_ctxt;

  // Empty flag after this update
  always_comb
  begin
    if (ex_fault)
      ex_empty = cur_empty;  // Unchanged
    else if (is_push)
      ex_empty = 1'b0;
    else
      ex_empty = last_link;
  end

  // State table writes, init has priority
  always_ff @(posedge clk)
  begin
    if (init_wr)
    begin
      empty_q[init_ctxt] <= 1'b1;  // Head and tail left stale
    end
    else if (do_push)
    begin
      empty_q[dec_ctxt] <= 1'b0;
      tail_q[dec_ctxt]  <= alloc_id;  // New link is the tail
      if (cur_empty)
      begin
        head_q[dec_ctxt] <= alloc_id;  // And the head of a fresh list
      end
    end
    else if (do_pop)
    begin
      if (last_link)
      begin
        empty_q[dec_ctxt] <= 1'b1;
      end
      else
      begin
        head_q[dec_ctxt] <= link_q[cur_head];  // Follow the chain
      end
    end
  end

  // Link table, chain the old tail to the new link
  always_ff @(posedge clk)
  begin
    if (do_push && !cur_empty)
    begin
      link_q[cur_tail] <= alloc_id;
    end
  end

  llq_free_pool llq_free_pool_inst (
    .clk            (clk),
    .rst            (rst),
    .alloc          (do_push),
    .release_en     (do_pop),
    .release_id     (cur_head),        // Popped link returns to the pool
    .alloc_id       (alloc_id),
    .any_free       (any_free),
    .all_alloc_next (pool_full_next)
  );

endmodule

`default_nettype wire

//--- source/llq_free_pool.sv
// Hands out the lowest free link; caller must not alloc when any_free is low
`default_nettype none

module llq_free_pool
  import llq_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              alloc,           // Take alloc_id at this edge
  input  logic              release_en,      // Return release_id at this edge
  input  logic [LINK_W-1:0] release_id,
  output logic [LINK_W-1:0] alloc_id,
  output logic              any_free,
  output logic              all_alloc_next   // Every link taken after this edge
);

  logic [NUM_LINK-1:0] used_q;       // One bit per link, set when allocated
  logic [NUM_LINK-1:0] used_nxt;
  logic [NUM_LINK-1:0] alloc_mask;
  logic [NUM_LINK-1:0] release_mask;

  // Priority search, lowest index wins
  always_comb
  begin
    alloc_id = '0;
    for (int i = NUM_LINK - 1; i >= 0; i--)
    begin
      if (!used_q[i])
      begin
        alloc_id = LINK_W'(i);
      end
    end
  end

  assign any_free = ~(&used_q);

  // One-hot update masks
  always_comb
  begin
    alloc_mask   = '0;
    release_mask = '0;
    if (alloc)
    begin
      alloc_mask[alloc_id] = 1'b1;
    end
    if (release_en)
    begin
      release_mask[release_id] = 1'b1;
    end
  end

  // Release of a link never coincides with its own allocation
  assign used_nxt       = (used_q | alloc_mask) & ~release_mask;
  assign all_alloc_next = &used_nxt;

  always_ff @(posedge clk)
  begin
    if (rst)
      used_q <= '0;  // Whole pool free
    else
      used_q <= used_nxt;
  end

endmodule

`default_nettype wire

//--- source/llq_pkg.sv
// Sizes fixed here for all RTL; NUM_CTXT and NUM_LINK must be powers of two
`default_nettype none

package llq_pkg;

  // Command payload width
  localparam int DATA_W = 32;

  // Number of independent queue contexts
  localparam int NUM_CTXT = 8;

  // Link entries shared by every context
  localparam int NUM_LINK = 16;

  // Index widths
  localparam int CTXT_W = $clog2(NUM_CTXT);  // Context select
  localparam int LINK_W = $clog2(NUM_LINK);  // Link address to the data store

  // Init sequencer
  // INIT_RESET is held during rst and clears context zero,
  // INIT_CLEAR walks the remaining contexts
  typedef enum logic [1:0] {
    INIT_RESET = 2'b00,
    INIT_CLEAR = 2'b01,
    INIT_DONE  = 2'b10
  } init_state_e;

  // Command opcode after decode
  typedef enum logic {
    OP_POP  = 1'b0,  // Take from head
    OP_PUSH = 1'b1   // Append at tail
  } cmd_op_e;

endpackage

`default_nettype wire

//--- source/llq_result.sv
// Lookup operands hold between pulses; the consumer must take every lkup_pass_r pulse
`default_nettype none

module llq_result
  import llq_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  // From execute
  input  logic                ex_valid,
  input  logic                ex_rnw,
  input  logic                ex_fault,
  input  logic                ex_empty,
  input  logic [LINK_W-1:0]   ex_addr,
  input  logic [DATA_W-1:0]   ex_data,
  input  logic [CTXT_W-1:0]   ex_ctxt,
  input  logic                pool_full_next,
  // Lookup side
  output logic                lkup_pass_r,
  output logic                lkup_rnw_r,
  output logic                lkup_fault_r,
  output logic [LINK_W-1:0]   lkup_addr_r,
  output logic [DATA_W-1:0]   lkup_data_r,
  // Status
  output logic [NUM_CTXT-1:0] empty_r,
  output logic                full_r
);

  // Pulse and fault flag
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lkup_pass_r  <= 1'b0;
      lkup_fault_r <= 1'b0;
    end
    else
    begin
      lkup_pass_r <= ex_valid;  // One pulse per command
      if (ex_valid)
      begin
        lkup_fault_r <= ex_fault;
      end
    end
  end

  // Operands, loaded only with a command
  always_ff @(posedge clk)
  begin
    if (ex_valid)
    begin
      lkup_rnw_r  <= ex_rnw;
      lkup_addr_r <= ex_addr;
      lkup_data_r <= ex_data;
    end
  end

  // Status flags track the table update at the same edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      empty_r <= '1;     // All contexts idle
      full_r  <= 1'b0;
    end
    else
    begin
      if (ex_valid)
      begin
        empty_r[ex_ctxt] <= ex_empty;
      end
      full_r <= pool_full_next;  // Also follows the pool with no command
    end
  end

endmodule

`default_nettype wire

//--- source/llq_top.sv
// Fixed 2-edge latency from command accept to lkup_pass_r; lookup side has no back-pressure
`default_nettype none

module llq_top
  import llq_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  // Command side
  input  logic                cmd_pass,
  input  logic                cmd_push,
  input  logic [DATA_W-1:0]   cmd_data,
  input  logic [CTXT_W-1:0]   cmd_ctxt,
  output logic                cmd_accept,
  // Lookup side
  output logic                lkup_pass_r,
  output logic                lkup_rnw_r,
  output logic [DATA_W-1:0]   lkup_data_r,
  output logic [LINK_W-1:0]   lkup_addr_r,
  output logic                lkup_fault_r,
  // Status
  output logic [NUM_CTXT-1:0] empty_r,
  output logic                full_r,
  output logic                busy_r
);

  // Decode to execute
  logic              dec_valid;
  cmd_op_e           dec_op;
  logic [CTXT_W-1:0] dec_ctxt;
  logic [DATA_W-1:0] dec_data;
  logic              init_wr;
  logic [CTXT_W-1:0] init_ctxt;

  // Execute to result
  logic              ex_valid;
  logic              ex_rnw;
  logic              ex_fault;
  logic              ex_empty;
  logic [LINK_W-1:0] ex_addr;
  logic [DATA_W-1:0] ex_data;
  logic [CTXT_W-1:0] ex_ctxt;
  logic              pool_full_next;

  llq_decode llq_decode_inst (
    .clk        (clk),
    .rst        (rst),
    .cmd_pass   (cmd_pass),
    .cmd_push   (cmd_push),
    .cmd_data   (cmd_data),
    .cmd_ctxt   (cmd_ctxt),
    .cmd_accept (cmd_accept),
    .busy_r     (busy_r),
    .dec_valid  (dec_valid),
    .dec_op     (dec_op),
    .dec_ctxt   (dec_ctxt),
    .dec_data   (dec_data),
    .init_wr    (init_wr),
    .init_ctxt  (init_ctxt)
  );

  llq_execute llq_execute_inst (
    .clk            (clk),
    .rst            (rst),
    .dec_valid      (dec_valid),
    .dec_op         (dec_op),
    .dec_ctxt       (dec_ctxt),
    .dec_data       (dec_data),
    .init_wr        (init_wr),
    .init_ctxt      (init_ctxt),
    .ex_valid       (ex_valid),
    .ex_rnw         (ex_rnw),
    .ex_fault       (ex_fault),
    .ex_empty       (ex_empty),
    .ex_addr        (ex_addr),
    .ex_data        (ex_data),
    .ex_ctxt        (ex_ctxt),
    .pool_full_next (pool_full_next)
  );

  llq_result llq_result_inst (
    .clk            (clk),
    .rst            (rst),
    .ex_valid       (ex_valid),
    .ex_rnw         (ex_rnw),
    .ex_fault       (ex_fault),
    .ex_empty       (ex_empty),
    .ex_addr        (ex_addr),
    .ex_data        (ex_data),
    .ex_ctxt        (ex_ctxt),
    .pool_full_next (pool_full_next),
    .lkup_pass_r    (lkup_pass_r),
    .lkup_rnw_r     (lkup_rnw_r),
    .lkup_fault_r   (lkup_fault_r),
    .lkup_addr_r    (lkup_addr_r),
    .lkup_data_r    (lkup_data_r),
    .empty_r        (empty_r),
    .full_r         (full_r)
  );

endmodule

`default_nettype wire

//--- verif/llq_tb.sv
// Directed tests against a model of the context lists and free pool; expects NUM_LINK >= NUM_CTXT
`default_nettype none

module llq_tb
  import llq_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PULSE_WAIT = 20;            // Cycles allowed per lookup pulse
  localparam int INIT_WAIT  = 4 * NUM_CTXT;  // Cycles allowed for the init walk
  localparam int RAND_CMDS  = 48;

  logic                clk;
  logic                rst;
  logic                cmd_pass;
  logic                cmd_push;
  logic [DATA_W-1:0]   cmd_data;
  logic [CTXT_W-1:0]   cmd_ctxt;
  logic                cmd_accept;
  logic                lkup_pass_r;
  logic                lkup_rnw_r;
  logic [DATA_W-1:0]   lkup_data_r;
  logic [LINK_W-1:0]   lkup_addr_r;
  logic                lkup_fault_r;
  logic [NUM_CTXT-1:0] empty_r;
  logic                full_r;
  logic                busy_r;

  // Reference model of one ordered link list per context
  logic [LINK_W-1:0]   mlist [NUM_CTXT][NUM_LINK];
  int                  mcount [NUM_CTXT];
  logic [NUM_LINK-1:0] mused;                // Allocated links

  // Pending stimulus and expected lookups in command order
  logic                st_push [$];
  logic [CTXT_W-1:0]   st_ctxt [$];
  logic [DATA_W-1:0]   st_data [$];
  logic                exp_rnw [$];
  logic                exp_fault [$];
  logic [LINK_W-1:0]   exp_addr [$];
  logic [DATA_W-1:0]   exp_data [$];
  logic [NUM_CTXT-1:0] exp_empty [$];
  logic                exp_full [$];

  int seed;
  int test_errs;
  int total_errs;
  int tests_run;
  int tests_failed;

  llq_top llq_top_inst (
    .clk          (clk),
    .rst          (rst),
    .cmd_pass     (cmd_pass),
    .cmd_push     (cmd_push),
    .cmd_data     (cmd_data),
    .cmd_ctxt     (cmd_ctxt),
    .cmd_accept   (cmd_accept),
    .lkup_pass_r  (lkup_pass_r),
    .lkup_rnw_r   (lkup_rnw_r),
    .lkup_data_r  (lkup_data_r),
    .lkup_addr_r  (lkup_addr_r),
    .lkup_fault_r (lkup_fault_r),
    .empty_r      (empty_r),
    .full_r       (full_r),
    .busy_r       (busy_r)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic check_value(input string sig, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] want);
    assert (got === want)
    else
    begin
      $display("ERROR: %s = 0x%0h, expected 0x%0h", sig, got, want);
      test_errs++;
    end
  endtask

  // Queue one command and derive its lookup from the model
  task automatic plan_cmd(input logic push, input logic [CTXT_W-1:0] ctxt,
                          input logic [DATA_W-1:0] data);
    logic                fault;
    logic                found;
    logic [LINK_W-1:0]   addr;
    logic [NUM_CTXT-1:0] emp;
    fault = 1'b0;
    found = 1'b0;
    addr  = '0;
    if (push)
    begin
      for (int i = 0; i < NUM_LINK; i++)
      begin
        if (!found && !mused[i])
        begin
          addr  = LINK_W'(i);  // Lowest free link
          found = 1'b1;
        end
      end
      fault = !found;
      if (found)
      begin
        mused[addr] = 1'b1;
        mlist[ctxt][mcount[ctxt]] = addr;  // Append at tail
        mcount[ctxt]++;
      end
    end
    else if (mcount[ctxt] == 0)
      fault = 1'b1;  // Empty pop
    else
    begin
      addr = mlist[ctxt][0];  // Take from head
      for (int i = 1; i < mcount[ctxt]; i++)
        mlist[ctxt][i-1] = mlist[ctxt][i];
      mcount[ctxt]--;
      mused[addr] = 1'b0;
    end
    for (int c = 0; c < NUM_CTXT; c++)
      emp[c] = (mcount[c] == 0);
    st_push.push_back(push);
    st_ctxt.push_back(ctxt);
    st_data.push_back(data);
    exp_rnw.push_back(!push);
    exp_fault.push_back(fault);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_empty.push_back(emp);
    exp_full.push_back(&mused);
  endtask

  // One command per cycle back to back
  task automatic drive_cmds();
    while (st_push.size() > 0)
    begin
      @(posedge clk);
      cmd_pass <= 1'b1;
      cmd_push <= st_push.pop_front();
      cmd_ctxt <= st_ctxt.pop_front();
      cmd_data <= st_data.pop_front();
    end
    @(posedge clk);
    cmd_pass <= 1'b0;
  endtask

  task automatic collect_results(input int n);
    int   waited;
    logic fault;
    logic rnw;
    for (int k = 0; k < n; k++)
    begin
      waited = 0;
      do
      begin
        @(negedge clk);  // Outputs settled mid-cycle
        waited++;
      end
      while (!lkup_pass_r && waited < PULSE_WAIT);
      if (!lkup_pass_r)
      begin
        $display("No lookup pulse for command %0d within %0d cycles", k, PULSE_WAIT);
        test_errs++;
        exp_rnw.delete();
        exp_fault.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_empty.delete();
        exp_full.delete();
        return;
      end
      rnw   = exp_rnw.pop_front();
      fault = exp_fault.pop_front();
      check_value("lkup_rnw_r", lkup_rnw_r, rnw);
      check_value("lkup_fault_r", lkup_fault_r, fault);
      if (!fault)
        check_value("lkup_addr_r", lkup_addr_r, exp_addr[0]);
      if (!fault && !rnw)
        check_value("lkup_data_r", lkup_data_r, exp_data[0]);
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      check_value("empty_r", empty_r, exp_empty.pop_front());
      check_value("full_r", full_r, exp_full.pop_front());
    end
  endtask

  task automatic run_cmds();
    int n;
    n = st_push.size();
    fork
      drive_cmds();
      collect_results(n);
    join
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errs == 0)
      $display("%s: ok", name);
    else
    begin
      tests_failed++;
      $display("%s: %0d errors", name, test_errs);
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // Pops every model list dry
  task automatic drain_all();
    int cnt;
    for (int c = 0; c < NUM_CTXT; c++)
    begin
      cnt = mcount[c];
      repeat (cnt) plan_cmd(1'b0, CTXT_W'(c), '0);
    end
    run_cmds();
  endtask

  task automatic check_init();
    int waited;
    waited = 0;
    @(negedge clk);
    check_value("busy_r", busy_r, 1'b1);
    check_value("cmd_accept", cmd_accept, 1'b0);
    check_value("lkup_pass_r", lkup_pass_r, 1'b0);
    check_value("lkup_fault_r", lkup_fault_r, 1'b0);
    while (busy_r && waited < INIT_WAIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (busy_r)
    begin
      $display("busy_r still high %0d cycles after reset", INIT_WAIT);
      test_errs++;
    end
    check_value("cmd_accept", cmd_accept, 1'b1);
    check_value("empty_r", empty_r, {NUM_CTXT{1'b1}});
    check_value("full_r", full_r, 1'b0);
    report_test("init");
  endtask

  task automatic fifo_order();
    for (int i = 0; i < 3; i++)
      plan_cmd(1'b1, CTXT_W'(3), DATA_W'(32'hA5A5_0000 + i));
    repeat (3) plan_cmd(1'b0, CTXT_W'(3), '0);
    run_cmds();
    report_test("fifo_order");
  endtask

  task automatic interleaved_traffic();
    int r;
    for (int i = 0; i < RAND_CMDS; i++)
    begin
      r = $random(seed);
      plan_cmd(r[11:8] < 4'd10, r[CTXT_W-1:0], $random(seed));  // Push-biased mix
    end
    run_cmds();
    drain_all();
    report_test("interleaved");
  endtask

  task automatic pop_from_empty();
    plan_cmd(1'b1, CTXT_W'(5), 32'hDEAD_0001);
    plan_cmd(1'b0, CTXT_W'(5), '0);  // Stale head left behind
    plan_cmd(1'b1, CTXT_W'(1), 32'hDEAD_0002);  // Same link now held by context 1
    plan_cmd(1'b0, CTXT_W'(5), '0);  // Faults
    plan_cmd(1'b1, CTXT_W'(5), 32'hDEAD_0005);
    run_cmds();
    drain_all();
    report_test("pop_empty");
  endtask

  task automatic pool_exhaustion();
    for (int i = 0; i < NUM_LINK; i++)
      plan_cmd(1'b1, CTXT_W'(i % NUM_CTXT), DATA_W'(32'h0F00_0000 + i));
    plan_cmd(1'b1, CTXT_W'(0), 32'hFFFF_FFFF);  // No free link
    plan_cmd(1'b0, CTXT_W'(2), '0);
    plan_cmd(1'b1, CTXT_W'(6), 32'h0F00_00AA);  // Reuses the popped link
    run_cmds();
    drain_all();  // Context 0 chain must be intact
    report_test("pool_full");
  endtask

  initial
  begin
    rst          = 1'b1;
    cmd_pass     = 1'b0;
    cmd_push     = 1'b0;
    cmd_data     = '0;
    cmd_ctxt     = '0;
    seed         = 55;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    mused        = '0;
    for (int c = 0; c < NUM_CTXT; c++)
      mcount[c] = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    check_init();
    fifo_order();
    interleaved_traffic();
    pop_from_empty();
    pool_exhaustion();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
